/* source/chess_pkg.sv */
package chess_pkg;

	localparam int NUM_FILES = 8;

	// piece kinds, empty square is all zero
	typedef enum logic [2:0] {
		EMPTY  = 3'd0,
		PAWN   = 3'd1,
		KNIGHT = 3'd2,
		BISHOP = 3'd3,
		ROOK   = 3'd4,
		QUEEN  = 3'd5,
		KING   = 3'd6
	} piece_kind_e;

	typedef struct packed {
		logic        black;
		piece_kind_e kind;
	} piece_t;

	// index is rank*8 + file
	typedef struct packed {
		logic [2:0] rank;
		logic [2:0] file;
	} square_t;

	// square 0 (file a, rank 1) sits in bits 3:0
	typedef piece_t [63:0] board_t;

endpackage

/* source/lmg_pkg.sv */
package lmg_pkg;

	localparam int COL_FIFO_DEPTH_DEFAULT = 32;
	localparam int OUT_FIFO_DEPTH_DEFAULT = 128;

	// capture flag then from and to squares
	typedef struct packed {
		logic              capture;
		chess_pkg::square_t from;
		chess_pkg::square_t to;
	} move_t;

	typedef enum logic [1:0] {
		WAIT = 2'b01,
		GETM = 2'b11,
		DONE = 2'b10
	} collect_state_e;

endpackage

/* source/move_fifo.sv */
`timescale 1ns/1ps

// depth must be a power of two, pointers wrap naturally
module move_fifo #(
	parameter int DEPTH = 32
) (
	input  logic           clk,
	input  logic           reset,
	input  logic           wr,
	input  lmg_pkg::move_t wdata,
	input  logic           rd,
	output lmg_pkg::move_t rdata,
	output logic           empty,
	output logic           full
);

	localparam int AW = $clog2(DEPTH);

	lmg_pkg::move_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wr_ptr] <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr, rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	// show-ahead head word
	assign rdata = mem[rd_ptr];
	assign empty = (count == '0);
	assign full  = (count == (AW+1)'(DEPTH));

	assert property (@(posedge clk) disable iff (reset) !(wr && full))
		else $error("move_fifo: write while full");

	assert property (@(posedge clk) disable iff (reset) !(rd && empty))
		else $error("move_fifo: read while empty");

endmodule

/* source/board_regs.sv */
`timescale 1ns/1ps

module board_regs (
	input  logic              clk,
	input  logic              reset,
	input  logic              start,
	input  chess_pkg::board_t bstate,
	input  logic              side,
	output chess_pkg::board_t board,
	output logic              side_q,
	output logic              go
);

	// position snapshot for the column units
	always_ff @(posedge clk) begin
		if (start) begin
			board  <= bstate;
			side_q <= side;
		end
	end

	// scan starts once the snapshot is stable
	always_ff @(posedge clk) begin
		if (reset) begin
			go <= 1'b0;
		end else begin
			go <= start;
		end
	end

endmodule

/* source/column_unit.sv */
`timescale 1ns/1ps

module column_unit #(
	parameter int FILE           = 0,
	parameter int COL_FIFO_DEPTH = lmg_pkg::COL_FIFO_DEPTH_DEFAULT
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              go,
	input  chess_pkg::board_t board,
	input  logic              side,
	input  logic              col_rd,
	output lmg_pkg::move_t    col_head,
	output logic              col_empty,
	output logic              col_done
);

	logic [6:0] cnt;
	logic busy;
	logic [2:0] src_rank;
	logic [3:0] off_idx;
	logic signed [3:0] d_rank;
	logic signed [3:0] d_file;
	logic signed [4:0] t_rank;
	logic signed [4:0] t_file;
	logic on_board;
	logic kind_ok;
	chess_pkg::square_t from_sq;
	chess_pkg::square_t to_sq;
	chess_pkg::piece_t src;
	chess_pkg::piece_t dst;
	logic wr;
	lmg_pkg::move_t wdata;

	// counter walks rank in the high bits, offset in the low bits
	assign src_rank = cnt[6:4];
	assign off_idx  = cnt[3:0];

	always_comb begin
		case (off_idx)
			// knight jumps
			4'd0:  {d_rank, d_file} = {4'sd2, 4'sd1};
			4'd1:  {d_rank, d_file} = {4'sd2, -4'sd1};
			4'd2:  {d_rank, d_file} = {-4'sd2, 4'sd1};
			4'd3:  {d_rank, d_file} = {-4'sd2, -4'sd1};
			4'd4:  {d_rank, d_file} = {4'sd1, 4'sd2};
			4'd5:  {d_rank, d_file} = {4'sd1, -4'sd2};
			4'd6:  {d_rank, d_file} = {-4'sd1, 4'sd2};
			4'd7:  {d_rank, d_file} = {-4'sd1, -4'sd2};
			// king steps
			4'd8:  {d_rank, d_file} = {4'sd1, -4'sd1};
			4'd9:  {d_rank, d_file} = {4'sd1, 4'sd0};
			4'd10: {d_rank, d_file} = {4'sd1, 4'sd1};
			4'd11: {d_rank, d_file} = {4'sd0, -4'sd1};
			4'd12: {d_rank, d_file} = {4'sd0, 4'sd1};
			4'd13: {d_rank, d_file} = {-4'sd1, -4'sd1};
			4'd14: {d_rank, d_file} = {-4'sd1, 4'sd0};
			default: {d_rank, d_file} = {-4'sd1, 4'sd1};
		endcase
	end

	assign t_rank = $signed({2'b00, src_rank}) + d_rank;
	assign t_file = $signed({2'b00, 3'(FILE)}) + d_file;

	// anything outside 0..7 has bit 3 or the sign bit set
	assign on_board = (t_rank[4:3] == 2'b00) && (t_file[4:3] == 2'b00);

	assign from_sq = '{rank: src_rank, file: 3'(FILE)};
	assign to_sq   = '{rank: t_rank[2:0], file: t_file[2:0]};
	assign src     = board[from_sq];
	assign dst     = board[to_sq];

	assign kind_ok = off_idx[3] ? (src.kind == chess_pkg::KING) : (src.kind == chess_pkg::KNIGHT);

	assign wr = busy && kind_ok && (src.black == side) && on_board &&
		!((dst.kind != chess_pkg::EMPTY) && (dst.black == side));

	assign wdata.capture = (dst.kind != chess_pkg::EMPTY) && (dst.black != side);
	assign wdata.from    = from_sq;
	assign wdata.to      = to_sq;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy     <= 1'b0;
			cnt      <= '0;
			col_done <= 1'b0;
		end else if (go) begin
			busy     <= 1'b1;
			cnt      <= '0;
			col_done <= 1'b0;
		end else if (busy) begin
			cnt <= cnt + 7'd1;
			if (&cnt) begin
				busy     <= 1'b0;
				col_done <= 1'b1;
			end
		end
	end

	move_fifo #(.DEPTH(COL_FIFO_DEPTH)) col_fifo (
		.clk   (clk),
		.reset (reset),
		.wr    (wr),
		.wdata (wdata),
		.rd    (col_rd),
		.rdata (col_head),
		.empty (col_empty),
		.full  ()
	);

endmodule

/* source/move_collector.sv */
`timescale 1ns/1ps

module move_collector #(
	parameter int OUT_FIFO_DEPTH = lmg_pkg::OUT_FIFO_DEPTH_DEFAULT
) (
	input  logic                                      clk,
	input  logic                                      reset,
	input  logic                                      start,
	input  logic [chess_pkg::NUM_FILES-1:0]           col_done,
	input  logic [chess_pkg::NUM_FILES-1:0]           col_empty,
	input  lmg_pkg::move_t [chess_pkg::NUM_FILES-1:0] col_heads,
	output logic [chess_pkg::NUM_FILES-1:0]           col_rd,
	input  logic                                      rden,
	output lmg_pkg::move_t                            fifo_out,
	output logic                                      fifo_empty,
	output logic                                      done
);

	localparam int PW = $clog2(chess_pkg::NUM_FILES);

	lmg_pkg::collect_state_e state;
	logic [chess_pkg::NUM_FILES-1:0] drained;
	logic [PW-1:0] ptr;
	logic [PW-1:0] pick;
	logic pick_valid;
	logic start_q;
	logic pop;

	// lowest finished file not yet drained
	always_comb begin
		pick_valid = 1'b0;
		pick       = '0;
		for (int i = chess_pkg::NUM_FILES - 1; i >= 0; i--) begin
			if (col_done[i] && !drained[i]) begin
				pick_valid = 1'b1;
				pick       = PW'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= lmg_pkg::WAIT;
			drained <= '0;
			ptr     <= '0;
			start_q <= 1'b0;
		end else begin
			start_q <= start;
			if (start) begin
				state   <= lmg_pkg::WAIT;
				drained <= '0;
			end else begin
				case (state)
					lmg_pkg::WAIT: begin
						// col_done still shows the old board in the cycle after start
						if (&drained) begin
							state <= lmg_pkg::DONE;
						end else if (pick_valid && !start_q) begin
							ptr   <= pick;
							state <= lmg_pkg::GETM;
						end
					end
					lmg_pkg::GETM: begin
						if (col_empty[ptr]) begin
							drained[ptr] <= 1'b1;
							state        <= lmg_pkg::WAIT;
						end
					end
					default: state <= lmg_pkg::DONE;
				endcase
			end
		end
	end

	// one word per cycle from the selected column
	assign pop = (state == lmg_pkg::GETM) && !col_empty[ptr];

	always_comb begin
		col_rd      = '0;
		col_rd[ptr] = pop;
	end

	assign done = (state == lmg_pkg::DONE);

	move_fifo #(.DEPTH(OUT_FIFO_DEPTH)) out_fifo (
		.clk   (clk),
		.reset (reset),
		.wr    (pop),
		.wdata (col_heads[ptr]),
		.rd    (rden && !fifo_empty),
		.rdata (fifo_out),
		.empty (fifo_empty),
		.full  ()
	);

	// only a finished column is ever drained, and one at a time
	assert property (@(posedge clk) disable iff (reset)
		$onehot0(col_rd) && ((col_rd & ~col_done) == '0))
		else $error("move_collector: bad column read strobe %b", col_rd);

endmodule

/* source/lmg.sv */
`timescale 1ns/1ps

module lmg #(
	parameter int COL_FIFO_DEPTH = lmg_pkg::COL_FIFO_DEPTH_DEFAULT,
	parameter int OUT_FIFO_DEPTH = lmg_pkg::OUT_FIFO_DEPTH_DEFAULT
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              start,
	input  chess_pkg::board_t bstate,
	input  logic              side,
	input  logic              rden,
	output lmg_pkg::move_t    fifo_out,
	output logic              fifo_empty,
	output logic              done
);

	chess_pkg::board_t board;
	logic side_q;
	logic go;
	logic [chess_pkg::NUM_FILES-1:0] col_done;
	logic [chess_pkg::NUM_FILES-1:0] col_empty;
	logic [chess_pkg::NUM_FILES-1:0] col_rd;
	lmg_pkg::move_t [chess_pkg::NUM_FILES-1:0] col_heads;

	board_regs board_regs_i (
		.clk    (clk),
		.reset  (reset),
		.start  (start),
		.bstate (bstate),
		.side   (side),
		.board  (board),
		.side_q (side_q),
		.go     (go)
	);

	// one scanner per file, a to h
	for (genvar f = 0; f < chess_pkg::NUM_FILES; f++) begin : g_col
		column_unit #(
			.FILE           (f),
			.COL_FIFO_DEPTH (COL_FIFO_DEPTH)
		) column_i (
			.clk       (clk),
			.reset     (reset),
			.go        (go),
			.board     (board),
			.side      (side_q),
			.col_rd    (col_rd[f]),
			.col_head  (col_heads[f]),
			.col_empty (col_empty[f]),
			.col_done  (col_done[f])
		);
	end

	move_collector #(.OUT_FIFO_DEPTH(OUT_FIFO_DEPTH)) collector_i (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.col_done   (col_done),
		.col_empty  (col_empty),
		.col_heads  (col_heads),
		.col_rd     (col_rd),
		.rden       (rden),
		.fifo_out   (fifo_out),
		.fifo_empty (fifo_empty),
		.done       (done)
	);

endmodule

/* verif/lmg_tb.sv */
`timescale 1ns/1ps

module lmg_tb;

	localparam int NUM_BOARDS = 6;
	localparam int CYCLES_PER_BOARD = 320;
	localparam int MAX_CYCLES = NUM_BOARDS * CYCLES_PER_BOARD + 80;

	logic clk;
	logic reset;
	logic start;
	chess_pkg::board_t bstate;
	logic side;
	logic rden;
	lmg_pkg::move_t fifo_out;
	logic fifo_empty;
	logic done;

	integer seed;
	int cycles;
	chess_pkg::board_t cur_board;
	bit cur_side;
	int exp_count;
	int popped;
	bit got [4096];

	lmg dut_i (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.bstate     (bstate),
		.side       (side),
		.rden       (rden),
		.fifo_out   (fifo_out),
		.fifo_empty (fifo_empty),
		.done       (done)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_eq(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		assert (actual === expected)
		else stop_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, actual, expected));
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
			stop_run($sformatf("timeout, run still busy after %0d cycles", cycles));
	end

	// knight jumps and single king steps only
	function automatic bit shape_fits(chess_pkg::piece_kind_e kind, int dr, int df);
		int ar;
		int af;
		ar = (dr < 0) ? -dr : dr;
		af = (df < 0) ? -df : df;
		if (kind == chess_pkg::KNIGHT)
			return (ar == 1 && af == 2) || (ar == 2 && af == 1);
		if (kind == chess_pkg::KING)
			return (ar <= 1) && (af <= 1) && (ar + af > 0);
		return 1'b0;
	endfunction

	function automatic bit is_legal(chess_pkg::board_t bd, bit sd, int from, int to);
		chess_pkg::piece_t src;
		chess_pkg::piece_t dst;
		src = bd[from];
		dst = bd[to];
		if (src.black != sd)
			return 1'b0;
		if (dst.kind != chess_pkg::EMPTY && dst.black == sd)
			return 1'b0;
		return shape_fits(src.kind, to / 8 - from / 8, to % 8 - from % 8);
	endfunction

	task automatic place(input chess_pkg::piece_t p);
		int sq;
		sq = $unsigned($random(seed)) % 64;
		while (cur_board[sq].kind != chess_pkg::EMPTY)
			sq = (sq + 1) % 64;
		cur_board[sq] = p;
	endtask

	task automatic make_board(input bit sd, input bit own_pieces);
		int n;
		chess_pkg::piece_kind_e kind;
		cur_board = '0;
		cur_side  = sd;
		if (own_pieces) begin
			place('{black: sd, kind: chess_pkg::KING});
			n = $unsigned($random(seed)) % 5;
			repeat (n) place('{black: sd, kind: chess_pkg::KNIGHT});
			// own blockers
			repeat (3) place('{black: sd, kind: chess_pkg::PAWN});
		end
		n = 4 + $unsigned($random(seed)) % 6;
		repeat (n) begin
			kind = chess_pkg::piece_kind_e'(1 + $unsigned($random(seed)) % 6);
			place('{black: !sd, kind: kind});
		end
	endtask

	task automatic take_move(input lmg_pkg::move_t m);
		int f;
		int t;
		f = int'(m.from);
		t = int'(m.to);
		assert (is_legal(cur_board, cur_side, f, t))
		else stop_run($sformatf("popped move %0d to %0d is not a knight or king move", f, t));
		check_eq("fifo_out.capture", m.capture,
			cur_board[t].kind != chess_pkg::EMPTY && cur_board[t].black != cur_side);
		assert (!got[f * 64 + t])
		else stop_run($sformatf("move %0d to %0d popped twice", f, t));
		got[f * 64 + t] = 1'b1;
		popped++;
	endtask

	// one read cycle with the head word sampled at the falling edge
	task automatic read_step(input bit want);
		bit idle;
		rden = want;
		if (want && !fifo_empty)
			take_move(fifo_out);
		if (exp_count == 0)
			assert (fifo_empty) else stop_run("output FIFO not empty for a board without moves");
		idle = want && fifo_empty && done;
		@(negedge clk);
		if (idle)
			assert (fifo_empty) else stop_run("read of an empty output FIFO cleared fifo_empty");
	endtask

	task automatic run_board(input int idx);
		make_board(idx[0], idx != 3);
		exp_count = 0;
		for (int f = 0; f < 64; f++)
			for (int t = 0; t < 64; t++)
				exp_count += is_legal(cur_board, cur_side, f, t);
		for (int i = 0; i < 4096; i++)
			got[i] = 1'b0;
		popped = 0;
		bstate = cur_board;
		side   = cur_side;
		start  = 1'b1;
		@(negedge clk);
		start = 1'b0;
		check_eq("done", done, 0);
		while (!done)
			read_step($random(seed) & 1);
		while (!fifo_empty)
			read_step(1'b1);
		// extra reads on the empty FIFO
		read_step(1'b1);
		read_step(1'b1);
		read_step(1'b0);
		check_eq("popped count", popped, exp_count);
	endtask

	initial begin
		seed   = 75071;
		cycles = 0;
		reset  = 1'b1;
		start  = 1'b0;
		bstate = '0;
		side   = 1'b0;
		rden   = 1'b0;
		exp_count = 0;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		check_eq("done", done, 0);
		check_eq("fifo_empty", fifo_empty, 1);
		for (int b = 0; b < NUM_BOARDS; b++)
			run_board(b);
		$display("TEST OK");
		$finish;
	end

endmodule

/* lmg.f */
source/chess_pkg.sv
source/lmg_pkg.sv
source/move_fifo.sv
source/board_regs.sv
source/column_unit.sv
source/move_collector.sv
source/lmg.sv
verif/lmg_tb.sv

/* Bender.yml */
package:
  name: lmg

sources:
  - files:
      - source/chess_pkg.sv
      - source/lmg_pkg.sv
      - source/move_fifo.sv
      - source/board_regs.sv
      - source/column_unit.sv
      - source/move_collector.sv
      - source/lmg.sv
  - target: test
    files:
      - verif/lmg_tb.sv
